// ==== logic/gf64_pkg.sv ====
// Goldilocks field definitions shared by the NTT butterfly datapath
// p = 2^64 - 2^32 + 1, so 2^64 == 2^32 - 1 and 2^96 == -1 mod p
// Field width is fixed and is not meant to be overridden
`default_nettype none

package gf64_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int MOD_NTT_W = 64;
  // Half word used by the folding identities
  localparam int MID_W     = MOD_NTT_W / 2;
  // Signed partial-reduced operand with one extra magnitude bit and a sign bit
  localparam int OP_W      = MOD_NTT_W + 2;

  // --------------------
  // Field constants
  // --------------------
  localparam logic [MOD_NTT_W-1:0] GF64_P = 64'hFFFF_FFFF_0000_0001;

  // --------------------
  // Data types
  // --------------------
  // Canonical element in [0, p)
  typedef logic [MOD_NTT_W-1:0] gf64_t;
  // Two's complement value congruent to the element, not canonical
  typedef logic [OP_W-1:0]      gf64_pr_t;

endpackage

`default_nettype wire

// ==== logic/ntt_side_pkg.sv ====
// Side data carried next to each butterfly operation
// The datapath never looks inside this struct
`default_nettype none

package ntt_side_pkg;

  // Caller tag plus end-of-block marker
  typedef struct packed {
    logic [7:0] idx;
    logic       last;
  } bfly_side_t;

  // Flat width used by the generic delay lines
  localparam int SIDE_W = $bits(bfly_side_t);

endpackage

`default_nettype wire

// ==== logic/delay_side.sv ====
// Delay line for a valid strobe and its side data
// Avail and side registers clear on reset
// LATENCY of 0 turns the block into plain wires
`timescale 1ns/1ps
`default_nettype none

module delay_side #(
  parameter int LATENCY = 1,
  parameter int SIDE_W  = 1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_avail,
  output logic              out_avail,
  input  logic [SIDE_W-1:0] in_side,
  output logic [SIDE_W-1:0] out_side
);

  if (LATENCY < 0) begin : gen_bad_latency
    $fatal(1, "delay_side: LATENCY (%0d) must not be negative", LATENCY);
  end

  if (LATENCY == 0) begin : gen_no_delay
    assign out_avail = in_avail;
    assign out_side  = in_side;
  end else begin : gen_delay
    logic [LATENCY-1:0]             avail_q;
    logic [LATENCY-1:0][SIDE_W-1:0] side_q;

    always_ff @(posedge clk) begin
      if (reset) begin
        avail_q <= '0;
        side_q  <= '0;
      end else begin
        avail_q[0] <= in_avail;
        side_q[0]  <= in_side;
        // Remaining stages shift one step per cycle
        for (int i = 1; i < LATENCY; i++) begin
          avail_q[i] <= avail_q[i-1];
          side_q[i]  <= side_q[i-1];
        end
      end
    end

    assign out_avail = avail_q[LATENCY-1];
    assign out_side  = side_q[LATENCY-1];
  end

  // Downstream logic trusts the strobe to be a clean 0 or 1 once out of reset
  assert property (@(posedge clk) disable iff (reset) !$isunknown(out_avail))
    else $error("delay_side: out_avail is unknown");

endmodule

`default_nettype wire

// ==== logic/gf64_pmr_shift_cst.sv ====
// Multiply a signed operand by +/-2^CST with partial reduction mod p
// Input and output are two's complement OP_W values, output is not canonical
// CST + OP_W must not exceed 160, so CST is at most 94 here
// Latency is 2 cycles, one input register and one output register
`timescale 1ns/1ps
`default_nettype none

module gf64_pmr_shift_cst
  import gf64_pkg::*;
#(
  parameter int CST      = 0,
  parameter bit CST_SIGN = 1'b0,
  parameter int SIDE_W   = 1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [OP_W-1:0]   a,
  output gf64_pr_t          z,
  input  logic              in_avail,
  output logic              out_avail,
  input  logic [SIDE_W-1:0] in_side,
  output logic [SIDE_W-1:0] out_side
);

  // Shift within a half word, the 2^32 multiples are handled by the fold
  localparam int SHIFT      = CST % MID_W;
  // Bits between 2^64 and the sign bit of the shifted word
  localparam int C_W        = OP_W - 1 + SHIFT - MOD_NTT_W;
  // Sign bit sits at 2^96 only when SHIFT is 31
  localparam bit IS_4_PARTS = (OP_W + SHIFT) > 3 * MID_W;

  if (CST < 0 || (CST + OP_W) > 5 * MID_W) begin : gen_bad_cst
    $fatal(1, "gf64_pmr_shift_cst: CST (%0d) + OP_W (%0d) must be at most %0d",
           CST, OP_W, 5 * MID_W);
  end

  // --------------------
  // Input stage
  // --------------------
  logic [OP_W-1:0]   s0_a;
  logic              s0_avail;
  logic [SIDE_W-1:0] s0_side;

  always_ff @(posedge clk) begin
    s0_a <= a;
  end

  delay_side #(
    .LATENCY (1),
    .SIDE_W  (SIDE_W)
  ) u_in_delay (
    .clk       (clk),
    .reset     (reset),
    .in_avail  (in_avail),
    .out_avail (s0_avail),
    .in_side   (in_side),
    .out_side  (s0_side)
  );

  // --------------------
  // Shift and fold
  // --------------------
  // Value of the shifted word is lo + carry*2^64 - sign*2^(64+C_W)
  logic [OP_W+SHIFT-1:0] s0_a_sh;
  logic [MID_W-1:0]      s0_lo;
  logic [MID_W-1:0]      s0_hi;
  logic [C_W-1:0]        s0_carry;
  logic                  s0_sign;
  gf64_pr_t              s0_red;
  gf64_pr_t              s0_z;

  assign s0_a_sh  = (OP_W + SHIFT)'(s0_a) << SHIFT;
  assign s0_lo    = s0_a_sh[0 +: MID_W];
  assign s0_hi    = s0_a_sh[MID_W +: MID_W];
  assign s0_carry = s0_a_sh[MOD_NTT_W +: C_W];
  assign s0_sign  = s0_a_sh[OP_W+SHIFT-1];

  // All sums wrap at OP_W bits, the true result always fits signed OP_W
  if (CST < MID_W) begin : gen_lt_mid_w
    // carry*2^64 -> carry*(2^32 - 1)
    if (IS_4_PARTS) begin : gen_4_parts
      // -sign*2^96 -> +sign
      assign s0_red = {s0_hi, s0_lo}
                      + {s0_carry, {MID_W{1'b0}}}
                      - s0_carry
                      + s0_sign;
    end else begin : gen_3_parts
      // -sign*2^(64+C_W) -> -sign*(2^(32+C_W) - 2^C_W)
      assign s0_red = {s0_hi, s0_lo}
                      + {s0_carry, {MID_W{1'b0}}}
                      - s0_carry
                      - {s0_sign, {(MID_W + C_W){1'b0}}}
                      + {s0_sign, {C_W{1'b0}}};
    end
  end else if (CST < MOD_NTT_W) begin : gen_lt_mod_ntt_w
    // Extra 2^32 moves lo up, hi lands on 2^64, carry on 2^96
    // Sign term at 2^(96+C_W) becomes +sign*2^C_W for 3 or 4 parts alike
    assign s0_red = {s0_lo, {MID_W{1'b0}}}
                    + {s0_hi, {MID_W{1'b0}}}
                    - s0_hi
                    - s0_carry
                    + {s0_sign, {C_W{1'b0}}};
  end else begin : gen_lt_mod_mid_w
    // Extra 2^64 puts lo on 2^64, hi on 2^96, carry on 2^128 == -2^32
    // 4 parts cannot occur here since CST <= 94 keeps SHIFT <= 30
    assign s0_red = {s0_lo, {MID_W{1'b0}}}
                    - s0_lo
                    - s0_hi
                    - {s0_carry, {MID_W{1'b0}}}
                    + {s0_sign, {(MID_W + C_W){1'b0}}};
  end

  // Negative twiddle
  if (CST_SIGN) begin : gen_neg
    assign s0_z = -s0_red;
  end else begin : gen_pos
    assign s0_z = s0_red;
  end

  // --------------------
  // Output stage
  // --------------------
  gf64_pr_t s1_z;

  always_ff @(posedge clk) begin
    s1_z <= s0_z;
  end

  delay_side #(
    .LATENCY (1),
    .SIDE_W  (SIDE_W)
  ) u_out_delay (
    .clk       (clk),
    .reset     (reset),
    .in_avail  (s0_avail),
    .out_avail (out_avail),
    .in_side   (s0_side),
    .out_side  (out_side)
  );

  assign z = s1_z;

endmodule

`default_nettype wire

// ==== logic/gf64_bfly_combine.sv ====
// Butterfly add and subtract of two partial-reduced operands
// Both results come out canonical in [0, p)
// Operands must lie in signed OP_W range, latency is 2 cycles
`timescale 1ns/1ps
`default_nettype none

module gf64_bfly_combine
  import gf64_pkg::*;
  import ntt_side_pkg::*;
#(
  parameter int SIDE_W = $bits(bfly_side_t)
) (
  input  logic       clk,
  input  logic       reset,
  input  gf64_pr_t   a_pr,
  input  gf64_pr_t   b_pr,
  input  logic       in_avail,
  input  bfly_side_t in_side,
  output gf64_t      z_add,
  output gf64_t      z_sub,
  output logic       out_avail,
  output bfly_side_t out_side
);

  // One growth bit for the sum of two OP_W values
  localparam int SUM_W = OP_W + 1;
  localparam logic signed [OP_W-1:0] P_EXT = {2'b00, GF64_P};

  if (SIDE_W != $bits(bfly_side_t)) begin : gen_bad_side_w
    $fatal(1, "gf64_bfly_combine: SIDE_W (%0d) must match bfly_side_t", SIDE_W);
  end

  // Fold bits 64 and up with 2^64 == 2^32 - 1, then one +/-p correction
  // Folded value lies in [-4*(2^32-1), 2^64 + 3*(2^32-1)) so one step is enough
  function automatic gf64_t fold_to_canon(logic signed [SUM_W-1:0] v);
    logic signed [OP_W-1:0] hi_ext;
    logic signed [OP_W-1:0] f;
    logic signed [OP_W-1:0] r;
    hi_ext = {{(OP_W-3){v[SUM_W-1]}}, v[SUM_W-1:MOD_NTT_W]};
    f      = $signed({2'b00, v[MOD_NTT_W-1:0]}) + (hi_ext <<< MID_W) - hi_ext;
    if (f < 0) begin
      r = f + P_EXT;
    end else if (f >= P_EXT) begin
      r = f - P_EXT;
    end else begin
      r = f;
    end
    return r[MOD_NTT_W-1:0];
  endfunction

  // --------------------
  // Stage 1
  // --------------------
  // Signed sum and difference, no overflow at SUM_W
  logic signed [SUM_W-1:0] s1_add;
  logic signed [SUM_W-1:0] s1_sub;

  always_ff @(posedge clk) begin
    s1_add <= $signed(a_pr) + $signed(b_pr);
    s1_sub <= $signed(a_pr) - $signed(b_pr);
  end

  // --------------------
  // Stage 2
  // --------------------
  gf64_t s2_add;
  gf64_t s2_sub;

  always_ff @(posedge clk) begin
    s2_add <= fold_to_canon(s1_add);
    s2_sub <= fold_to_canon(s1_sub);
  end

  // Strobe and side follow the two data stages
  delay_side #(
    .LATENCY (2),
    .SIDE_W  (SIDE_W)
  ) u_delay (
    .clk       (clk),
    .reset     (reset),
    .in_avail  (in_avail),
    .out_avail (out_avail),
    .in_side   (in_side),
    .out_side  (out_side)
  );

  assign z_add = s2_add;
  assign z_sub = s2_sub;

  // Any valid result leaving the butterfly is a canonical element
  assert property (@(posedge clk) disable iff (reset)
                   out_avail |-> (z_add < GF64_P) && (z_sub < GF64_P))
    else $error("gf64_bfly_combine: non-canonical output");

endmodule

`default_nettype wire

// ==== logic/gf64_ntt_bfly_cst.sv ====
// Radix-2 NTT butterfly over GF64 with constant twiddle w = +/-2^CST
// z_add = x + w*y, z_sub = x - w*y, both canonical
// x and y must be canonical, fixed latency of 4 cycles, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module gf64_ntt_bfly_cst
  import gf64_pkg::*;
  import ntt_side_pkg::*;
#(
  parameter int CST      = 24,
  parameter bit CST_SIGN = 1'b0
) (
  input  logic       clk,
  input  logic       reset,
  input  gf64_t      x,
  input  gf64_t      y,
  input  logic       in_avail,
  input  bfly_side_t in_side,
  output gf64_t      z_add,
  output gf64_t      z_sub,
  output logic       out_avail,
  output bfly_side_t out_side
);

  // Canonical inputs are non-negative, so zero bits make them signed OP_W
  gf64_pr_t   x_ext;
  gf64_pr_t   y_ext;
  gf64_pr_t   x_pr;
  gf64_pr_t   y_pr;
  logic       y_avail;
  bfly_side_t y_side;

  assign x_ext = {2'b00, x};
  assign y_ext = {2'b00, y};

  // Shift of 0 only matches format and latency with the y path
  gf64_pmr_shift_cst #(
    .CST      (0),
    .CST_SIGN (1'b0),
    .SIDE_W   (1)
  ) u_shift_x (
    .clk       (clk),
    .reset     (reset),
    .a         (x_ext),
    .z         (x_pr),
    .in_avail  (in_avail),
    .out_avail (),
    .in_side   (1'b0),
    .out_side  ()
  );

  // Twiddle multiply, carries the strobe and side data
  gf64_pmr_shift_cst #(
    .CST      (CST),
    .CST_SIGN (CST_SIGN),
    .SIDE_W   (SIDE_W)
  ) u_shift_y (
    .clk       (clk),
    .reset     (reset),
    .a         (y_ext),
    .z         (y_pr),
    .in_avail  (in_avail),
    .out_avail (y_avail),
    .in_side   (in_side),
    .out_side  (y_side)
  );

  gf64_bfly_combine #(
    .SIDE_W (SIDE_W)
  ) u_combine (
    .clk       (clk),
    .reset     (reset),
    .a_pr      (x_pr),
    .b_pr      (y_pr),
    .in_avail  (y_avail),
    .in_side   (y_side),
    .z_add     (z_add),
    .z_sub     (z_sub),
    .out_avail (out_avail),
    .out_side  (out_side)
  );

endmodule

`default_nettype wire

// ==== dv/gf64_ref.svh ====
// Reference arithmetic mod p for checking the butterfly
// Uses plain 128-bit math, slow but easy to trust
// Operands are expected canonical, results are always canonical
`ifndef GF64_REF_SVH
`define GF64_REF_SVH

function automatic gf64_pkg::gf64_t ref_add(gf64_pkg::gf64_t a, gf64_pkg::gf64_t b);
  logic [127:0] s;
  s = (128'(a) + 128'(b)) % 128'(gf64_pkg::GF64_P);
  return s[63:0];
endfunction

function automatic gf64_pkg::gf64_t ref_sub(gf64_pkg::gf64_t a, gf64_pkg::gf64_t b);
  logic [127:0] s;
  // Adding p first keeps the difference non-negative
  s = 128'(a) + 128'(gf64_pkg::GF64_P) - (128'(b) % 128'(gf64_pkg::GF64_P));
  s = s % 128'(gf64_pkg::GF64_P);
  return s[63:0];
endfunction

// y * (+/-2^cst) mod p, power built by repeated doubling
function automatic gf64_pkg::gf64_t ref_scale(gf64_pkg::gf64_t y, int unsigned cst,
                                              bit cst_sign);
  logic [127:0] w;
  logic [127:0] prod;
  int unsigned  i;
  w = 128'd1;
  for (i = 0; i < cst; i++) begin
    w = (w << 1) % 128'(gf64_pkg::GF64_P);
  end
  prod = (128'(y) * w) % 128'(gf64_pkg::GF64_P);
  if (cst_sign) begin
    prod = (128'(gf64_pkg::GF64_P) - prod) % 128'(gf64_pkg::GF64_P);
  end
  return prod[63:0];
endfunction

`endif

// ==== dv/tb_gf64_ntt_bfly.sv ====
// Testbench for the GF64 NTT butterfly with constant twiddle +/-2^CST
// CST, CST_SIGN and SEED may be overridden at elaboration
// Expects a fixed 4 cycle latency and in-order results
`timescale 1ns/1ps
`default_nettype none

module tb_gf64_ntt_bfly
  import gf64_pkg::*;
  import ntt_side_pkg::*;
#(
  parameter int          CST      = 24,
  parameter bit          CST_SIGN = 1'b0,
  parameter int unsigned SEED     = 90385
);

  `include "gf64_ref.svh"

  localparam int LATENCY       = 4;
  localparam int RESET_CYCLES  = 10;
  localparam int N_EDGE        = 36;
  localparam int N_RANDOM      = 2000;
  localparam int MAX_GAP       = 3;
  localparam int N_BURST       = 64;
  localparam int N_RESET_BURST = 20;
  localparam int N_RECOVER     = 8;
  // Worst case pairs plus idle gaps, reset windows and drain slack
  localparam int TIMEOUT_CYCLES = LATENCY * (N_EDGE + N_RANDOM * (1 + MAX_GAP) + N_BURST
                                  + N_RESET_BURST + N_RECOVER + 3 * RESET_CYCLES + 40) + 200;

  // One expected result, tagged with the cycle its pair was sent
  typedef struct packed {
    gf64_t       z_add;
    gf64_t       z_sub;
    bfly_side_t  side;
    logic [31:0] send_cycle;
  } bfly_exp_t;

  logic       clk = 1'b0;
  logic       reset;
  gf64_t      x;
  gf64_t      y;
  logic       in_avail;
  bfly_side_t in_side;
  gf64_t      z_add;
  gf64_t      z_sub;
  logic       out_avail;
  bfly_side_t out_side;

  bfly_exp_t   exp_q[$];
  logic [31:0] cycle = '0;
  // Reset level the DUT sampled at the last rising edge
  logic        reset_seen = 1'b1;
  int          sent_count    = 0;
  int          checked_count = 0;
  int          dropped_count = 0;

  gf64_ntt_bfly_cst #(
    .CST      (CST),
    .CST_SIGN (CST_SIGN)
  ) u_gf64_ntt_bfly_cst (
    .clk       (clk),
    .reset     (reset),
    .x         (x),
    .y         (y),
    .in_avail  (in_avail),
    .in_side   (in_side),
    .z_add     (z_add),
    .z_sub     (z_sub),
    .out_avail (out_avail),
    .out_side  (out_side)
  );

  always #2 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------
  task automatic stop_run(input string why);
    $display("Verification failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expv);
    if (got !== expv) begin
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, expv);
      stop_run($sformatf("%s mismatch", what));
    end
  endtask

  // x + w*y and x - w*y with w = +/-2^CST
  function automatic bfly_exp_t expected_bfly(gf64_t xv, gf64_t yv, bfly_side_t side,
                                              logic [31:0] cyc);
    bfly_exp_t e;
    gf64_t     wy;
    wy           = ref_scale(yv, CST, CST_SIGN);
    e.z_add      = ref_add(xv, wy);
    e.z_sub      = ref_sub(xv, wy);
    e.side       = side;
    e.send_cycle = cyc;
    return e;
  endfunction

  // Uniform-ish canonical element, one subtraction suffices below 2^64
  function automatic gf64_t random_element();
    gf64_t v;
    v = {$urandom(), $urandom()};
    if (v >= GF64_P) begin
      v = v - GF64_P;
    end
    return v;
  endfunction

  // --------------------
  // Stimulus tasks
  // --------------------
  task automatic send_pair(input gf64_t xv, input gf64_t yv, input logic last_v);
    bfly_side_t side;
    @(negedge clk);
    side.idx  = 8'(sent_count);
    side.last = last_v;
    x         = xv;
    y         = yv;
    in_side   = side;
    in_avail  = 1'b1;
    exp_q.push_back(expected_bfly(xv, yv, side, cycle));
    sent_count++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      in_avail = 1'b0;
    end
  endtask

  // Reset in the middle of traffic, in_avail drops with reset rising
  task automatic apply_reset();
    @(negedge clk);
    in_avail = 1'b0;
    reset    = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
  endtask

  // --------------------
  // Cycle counter and timeout
  // --------------------
  always @(posedge clk) begin
    cycle      <= cycle + 1;
    reset_seen <= reset;
    if (cycle >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("Timeout after %0d cycles, %0d pairs still outstanding",
                         cycle, exp_q.size()));
    end
  end

  // --------------------
  // Scoreboard
  // --------------------
  // Outputs are sampled mid-cycle, well away from the rising edge
  always @(negedge clk) begin : compare
    bfly_exp_t e;
    if (reset_seen === 1'b1) begin
      if (out_avail !== 1'b0) begin
        stop_run("out_avail is not low while the DUT is in reset");
      end else if (exp_q.size() != 0) begin
        // Pairs still in flight when reset hits never come out
        dropped_count += exp_q.size();
        exp_q.delete();
      end
    end else if ($isunknown(out_avail)) begin
      stop_run("out_avail is unknown outside reset");
    end else if (out_avail === 1'b1 && exp_q.size() == 0) begin
      stop_run("out_avail pulse with no pair outstanding");
    end else if (out_avail === 1'b1) begin
      e = exp_q.pop_front();
      check_value("latency", 64'(cycle - e.send_cycle), 64'(LATENCY));
      check_value("z_add", z_add, e.z_add);
      check_value("z_sub", z_sub, e.z_sub);
      check_value("out_side.idx", 64'(out_side.idx), 64'(e.side.idx));
      check_value("out_side.last", 64'(out_side.last), 64'(e.side.last));
      checked_count++;
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin : stimulus
    gf64_t edge_ops [6];
    int    i;
    int    j;
    reset    = 1'b1;
    in_avail = 1'b0;
    x        = '0;
    y        = '0;
    in_side  = '0;
    void'($urandom(SEED));

    // Note p-1 and 2^64-2^32 are the same value
    edge_ops[0] = 64'd0;
    edge_ops[1] = 64'd1;
    edge_ops[2] = GF64_P - 64'd1;
    edge_ops[3] = 64'h0000_0001_0000_0000;
    edge_ops[4] = 64'h0000_0000_FFFF_FFFF;
    edge_ops[5] = 64'hFFFF_FFFF_0000_0000;

    // Quiet outputs during and just after reset
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    idle_cycles(LATENCY + 2);

    // Edge operands in all pairings
    for (i = 0; i < 6; i++) begin
      for (j = 0; j < 6; j++) begin
        send_pair(edge_ops[i], edge_ops[j], j == 5);
      end
    end
    idle_cycles(2);

    // Random pairs with random idle gaps
    for (i = 0; i < N_RANDOM; i++) begin
      send_pair(random_element(), random_element(), (i % 16) == 15);
      idle_cycles($urandom_range(0, MAX_GAP));
    end
    idle_cycles(LATENCY + 2);

    // Back-to-back burst, one pair per cycle
    for (i = 0; i < N_BURST; i++) begin
      send_pair(random_element(), random_element(), i == N_BURST - 1);
    end
    idle_cycles(LATENCY + 2);

    // Reset in the middle of a burst, then recover
    for (i = 0; i < N_RESET_BURST; i++) begin
      send_pair(random_element(), random_element(), 1'b0);
    end
    apply_reset();
    idle_cycles(LATENCY + 2);
    for (i = 0; i < N_RECOVER; i++) begin
      send_pair(random_element(), random_element(), i == N_RECOVER - 1);
    end
    idle_cycles(1);

    // Drain, then watch for stray pulses
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    idle_cycles(LATENCY + 4);

    if (checked_count + dropped_count == sent_count && dropped_count == LATENCY - 1) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Sent %0d, checked %0d, dropped by reset %0d",
               sent_count, checked_count, dropped_count);
      stop_run("Pair count at end of run does not add up");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
logic/gf64_pkg.sv
logic/ntt_side_pkg.sv
logic/delay_side.sv
logic/gf64_pmr_shift_cst.sv
logic/gf64_bfly_combine.sv
logic/gf64_ntt_bfly_cst.sv
dv/tb_gf64_ntt_bfly.sv

// ==== Makefile ====
# Verilator flow for the GF64 NTT butterfly
# Override any variable on the command line, e.g. make sim CST=80 CST_SIGN=1

VERILATOR ?= verilator
TOP       ?= tb_gf64_ntt_bfly
FILELIST  ?= verilog.f
CST       ?= 24
CST_SIGN  ?= 0
SEED      ?= 90385
CST_LIST  ?= 0 24 48 80 94
SIGN_LIST ?= 0 1
BUILD_DIR ?= obj_dir_$(CST)_$(CST_SIGN)
LOG       ?= sim_$(CST)_$(CST_SIGN).log
PASS_MSG  := Verification passed

GFLAGS = -GCST=$(CST) -GCST_SIGN=$(CST_SIGN) -GSEED=$(SEED)

.PHONY: all lint sim regress clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) $(GFLAGS)

sim:
	rm -f $(LOG)
	$(VERILATOR) --binary --timing -Wno-fatal -f $(FILELIST) --top-module $(TOP) \
		$(GFLAGS) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS CST=$(CST) CST_SIGN=$(CST_SIGN)" || \
		(echo "FAIL CST=$(CST) CST_SIGN=$(CST_SIGN), see $(LOG)"; exit 1)

# Every shifter branch: below 32, below 64, below 96, both signs
regress:
	@for c in $(CST_LIST); do \
		for s in $(SIGN_LIST); do \
			$(MAKE) --no-print-directory sim CST=$$c CST_SIGN=$$s SEED=$(SEED) || exit 1; \
		done; \
	done

clean:
	rm -rf obj_dir_* sim_*.log
